// ==== run.sh ====
#!/usr/bin/env bash
# Build the SPI slave testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -j 0 --top-module spiSlaveTb -f sim.f -o spiSlaveSim
./obj_dir/spiSlaveSim | tee "$LOG"

if grep -q "Test failures found" "$LOG"; then
	echo "Simulation FAILED, see $LOG"
	exit 1
fi
echo "Simulation passed"

// ==== sim.f ====
+incdir+src
src/spiSlavePkg.sv
src/spiSlaveSignal.sv
src/spiSignalMux.sv
src/csrRegFile.sv
src/spiSlaveTop.sv
tests/spiSlaveTb.sv

// ==== src/csrRegFile.sv ====
/*
 Control and status registers
 Identity, bulk enable, scratch words and completed frame count
*/
`timescale 1ns/1ns
`include "spiSlave_cfg.svh"

module csrRegFile (
	input  logic                       iSysClk,
	input  logic                       rstN,
	input  spiSlavePkg::wordT          usiWd,
	input  logic [`BUS_ADRS_BIT-1:0]   usiAdrs,
	input  logic                       usiWEd,
	input  logic                       frameDone,
	output spiSlavePkg::wordT          usiRd,
	output logic                       bulkEn
);

	// Zero extended for full width decode
	spiSlavePkg::adrsT fullAdrs;
	spiSlavePkg::wordT scratch [`CSR_SCRATCH_NUM];
	// Wraps at 2^32 frames
	spiSlavePkg::wordT frameCnt;

	// Scratch registers sit at a fixed stride
	function automatic spiSlavePkg::adrsT scratchAdrs(input int idx);
		return spiSlavePkg::adrsT'(`CSR_SCRATCH0_ADRS
			+ idx * (`CSR_SCRATCH1_ADRS - `CSR_SCRATCH0_ADRS));
	endfunction

	assign fullAdrs = spiSlavePkg::adrsT'(usiAdrs);

	// ------------------------------
	// Writes
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			bulkEn <= 1'b0;
			for (int i = 0; i < `CSR_SCRATCH_NUM; i++)
				scratch[i] <= '0;
		end
		else if (usiWEd)
		begin
			// Control keeps bit 0 only
			if (fullAdrs == `CSR_CTRL_ADRS)
				bulkEn <= usiWd[0];
			for (int i = 0; i < `CSR_SCRATCH_NUM; i++)
			begin
				if (fullAdrs == scratchAdrs(i))
					scratch[i] <= usiWd;
			end
		end
	end

	// Completed frames, aborts never pulse
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
			frameCnt <= '0;
		else if (frameDone)
			frameCnt <= frameCnt + 32'd1;
	end

	// ------------------------------
	// Read mux
	// ------------------------------
	always_comb
	begin
		usiRd = '0;
		case (fullAdrs)
			`CSR_ID_ADRS:     usiRd = `CSR_ID_VALUE;
			`CSR_CTRL_ADRS:   usiRd = {31'd0, bulkEn};
			`CSR_FRAMES_ADRS: usiRd = frameCnt;
			default:          usiRd = '0;
		endcase
		for (int i = 0; i < `CSR_SCRATCH_NUM; i++)
		begin
			if (fullAdrs == scratchAdrs(i))
				usiRd = scratch[i];
		end
	end

endmodule

// ==== src/spiSignalMux.sv ====
/*
 Slave side bus arbiter
 Routes engine words to the register bus or the bulk write bus
*/
`timescale 1ns/1ns
`include "spiSlave_cfg.svh"

module spiSignalMux #(
	parameter int BUS_ADRS_BIT  = `BUS_ADRS_BIT,
	parameter int UFI_BUS_WIDTH = `UFI_BUS_WIDTH
) (
	input  logic                       iSysClk,
	input  logic                       rstN,
	// Frame engine side
	input  spiSlavePkg::wordT          sRd,
	input  spiSlavePkg::adrsT          sAdrs,
	input  spiSlavePkg::spiCmdE        sCmd,
	input  spiSlavePkg::dLenT          sDLen,
	input  logic                       sREd,
	output spiSlavePkg::wordT          sMiso,
	// Register bus
	input  spiSlavePkg::wordT          usiRd,
	input  logic                       bulkEn,
	output spiSlavePkg::wordT          usiWd,
	output logic [BUS_ADRS_BIT-1:0]    usiAdrs,
	output logic                       usiWEd,
	// Bulk write bus
	output logic [UFI_BUS_WIDTH-1:0]   ufiWd,
	output spiSlavePkg::adrsT          ufiAdrs,
	output logic                       ufiEd,
	output logic                       ufiVd
);

	// Register reads go straight back to the engine
	assign sMiso = usiRd;

	// ------------------------------
	// Payload, one cycle behind
	// ------------------------------

	// Tracks sAdrs every cycle so read decode stays current
	always_ff @(posedge iSysClk)
	begin
		usiWd   <= sRd;
		usiAdrs <= sAdrs[BUS_ADRS_BIT-1:0];
		// Low part of each 32 bit word only
		ufiWd   <= sRd[UFI_BUS_WIDTH-1:0];
		ufiAdrs <= sAdrs;
	end

	// ------------------------------
	// Strobe decode
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			usiWEd <= 1'b0;
			ufiEd  <= 1'b0;
			ufiVd  <= 1'b0;
		end
		else
		begin
			// Register write on a csrWrite word
			usiWEd <= sREd && (sCmd == spiSlavePkg::csrWrite);
			// Bulk word, dropped while bulk is disabled
			ufiEd  <= sREd && (sCmd == spiSlavePkg::bulkWrite) && bulkEn;
			// Transfer window while words remain
			ufiVd  <= (sDLen != '0) && (sCmd == spiSlavePkg::bulkWrite);
		end
	end

endmodule

// ==== src/spiSlavePkg.sv ====
/*
 SPI slave shared types
 Command encoding, field widths and frame engine states
*/
package spiSlavePkg;

	// ------------------------------
	// Frame fields
	// ------------------------------

	// Data word as shifted over SPI
	typedef logic [31:0] wordT;

	// Frame start address, bumped per bulk word
	typedef logic [31:0] adrsT;

	// Remaining word count of a frame
	typedef logic [15:0] dLenT;

	// ------------------------------
	// Command byte, low two bits
	// ------------------------------
	typedef enum logic [1:0]
	{
		csrRead   = 2'd0,
		csrWrite  = 2'd1,
		reserved  = 2'd2,
		bulkWrite = 2'd3
	} spiCmdE;

	// Frame engine phases
	typedef enum logic [2:0]
	{
		idle,
		cmdPhase,
		adrsPhase,
		lenPhase,
		dataPhase
	} frameStateE;

endpackage

// ==== src/spiSlaveSignal.sv ====
/*
 SPI mode 0 slave frame engine
 Oversamples the pins, splits frames into fields and shifts read data out
*/
`timescale 1ns/1ns

module spiSlaveSignal (
	input  logic                    iSysClk,
	input  logic                    rstN,
	input  logic                    sclk,
	input  logic                    csN,
	input  logic                    mosi,
	input  spiSlavePkg::wordT       sMiso,
	output logic                    miso,
	output spiSlavePkg::wordT       sRd,
	output spiSlavePkg::adrsT       sAdrs,
	output spiSlavePkg::spiCmdE     sCmd,
	output spiSlavePkg::dLenT       sDLen,
	output logic                    sREd,
	output logic                    frameDone
);

	// ------------------------------
	// Pin synchronizers
	// ------------------------------

	// Extra sclk stage for edge detect
	logic [2:0] sclkSr;
	logic [1:0] csNSr;
	logic [1:0] mosiSr;
	logic       sclkRise;
	logic       sclkFall;
	logic       csActive;

	// Frame engine state
	spiSlavePkg::frameStateE state;
	logic [4:0]              bitCnt;
	logic [4:0]              phaseLast;
	logic                    phaseEnd;
	spiSlavePkg::wordT       shiftReg;
	spiSlavePkg::wordT       shiftNext;
	// Read data going out on miso
	spiSlavePkg::wordT       misoSr;

	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			// Idle pin levels, no false edge out of reset
			sclkSr <= 3'b000;
			csNSr  <= 2'b11;
			mosiSr <= 2'b00;
		end
		else
		begin
			sclkSr <= {sclkSr[1:0], sclk};
			csNSr  <= {csNSr[0], csN};
			mosiSr <= {mosiSr[0], mosi};
		end
	end

	assign sclkRise = sclkSr[1] & ~sclkSr[2];
	assign sclkFall = ~sclkSr[1] & sclkSr[2];
	assign csActive = ~csNSr[1];

	// MSB first, new bit enters at the bottom
	assign shiftNext = {shiftReg[30:0], mosiSr[1]};

	// ------------------------------
	// Phase length in bits
	// ------------------------------
	always_comb
	begin
		case (state)
			spiSlavePkg::cmdPhase:  phaseLast = 5'd7;
			spiSlavePkg::adrsPhase: phaseLast = 5'd31;
			spiSlavePkg::lenPhase:  phaseLast = 5'd15;
			spiSlavePkg::dataPhase: phaseLast = 5'd31;
			default:                phaseLast = 5'd0;
		endcase
	end

	// Last bit of the current field sampled
	assign phaseEnd = sclkRise && (bitCnt == phaseLast);

	// Current bit of the read word
	assign miso = misoSr[31];

	// ------------------------------
	// Frame FSM
	// ------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (!rstN)
		begin
			state     <= spiSlavePkg::idle;
			bitCnt    <= 5'd0;
			sCmd      <= spiSlavePkg::csrRead;
			sDLen     <= '0;
			sREd      <= 1'b0;
			frameDone <= 1'b0;
			misoSr    <= '0;
		end
		else
		begin
			// Single cycle strobes
			sREd      <= 1'b0;
			frameDone <= 1'b0;

			// Next bulk address and count, the cycle after the strobe
			if (sREd && (sCmd == spiSlavePkg::bulkWrite))
			begin
				sAdrs <= sAdrs + 32'd1;
				sDLen <= sDLen - 16'd1;
			end

			if (!csActive)
			begin
				// Deselect aborts whatever is in flight
				state  <= spiSlavePkg::idle;
				bitCnt <= 5'd0;
				sDLen  <= '0;
				misoSr <= '0;
			end
			else
			begin
				if (sclkRise && (state != spiSlavePkg::idle))
				begin
					shiftReg <= shiftNext;
					bitCnt   <= bitCnt + 5'd1;
				end

				// Skip the fall right after the load, bit 31 is already out
				if (sclkFall && (state == spiSlavePkg::dataPhase) && (bitCnt != 5'd0))
					misoSr <= {misoSr[30:0], 1'b0};

				case (state)
					spiSlavePkg::idle:
					begin
						state  <= spiSlavePkg::cmdPhase;
						bitCnt <= 5'd0;
					end
					spiSlavePkg::cmdPhase:
					begin
						if (phaseEnd)
						begin
							// Upper six bits of the command byte ignored
							sCmd   <= spiSlavePkg::spiCmdE'(shiftNext[1:0]);
							bitCnt <= 5'd0;
							state  <= spiSlavePkg::adrsPhase;
						end
					end
					spiSlavePkg::adrsPhase:
					begin
						if (phaseEnd)
						begin
							sAdrs  <= shiftNext;
							bitCnt <= 5'd0;
							state  <= spiSlavePkg::lenPhase;
						end
					end
					spiSlavePkg::lenPhase:
					begin
						if (phaseEnd)
						begin
							bitCnt <= 5'd0;
							sDLen  <= shiftNext[15:0];
							// Register read data settled long before this edge
							misoSr <= (sCmd == spiSlavePkg::csrRead) ? sMiso : '0;
							if ((sCmd == spiSlavePkg::bulkWrite) && (shiftNext[15:0] == 16'd0))
							begin
								// Empty bulk frame ends here
								frameDone <= 1'b1;
								state     <= spiSlavePkg::idle;
							end
							else
								state <= spiSlavePkg::dataPhase;
						end
					end
					spiSlavePkg::dataPhase:
					begin
						if (phaseEnd)
						begin
							bitCnt <= 5'd0;
							sRd    <= shiftNext;
							sREd   <= 1'b1;
							if (sCmd != spiSlavePkg::bulkWrite)
							begin
								// Register frames carry one word only
								frameDone <= 1'b1;
								sDLen     <= '0;
								state     <= spiSlavePkg::idle;
							end
							else if (sDLen == 16'd1)
							begin
								frameDone <= 1'b1;
								state     <= spiSlavePkg::idle;
							end
						end
					end
					default:
						state <= spiSlavePkg::idle;
				endcase
			end
		end
	end

endmodule

// ==== src/spiSlaveTop.sv ====
/*
 SPI slave top level
 Frame engine, bus arbiter and register file
*/
`timescale 1ns/1ns
`include "spiSlave_cfg.svh"

module spiSlaveTop (
	input  logic                        iSysClk,
	input  logic                        rstN,
	// SPI pins
	input  logic                        sclk,
	input  logic                        csN,
	input  logic                        mosi,
	output logic                        miso,
	// Bulk write bus to external memory
	output logic [`UFI_BUS_WIDTH-1:0]   ufiWd,
	output spiSlavePkg::adrsT           ufiAdrs,
	output logic                        ufiEd,
	output logic                        ufiVd
);

	// Engine to arbiter
	spiSlavePkg::wordT       sRd;
	spiSlavePkg::adrsT       sAdrs;
	spiSlavePkg::spiCmdE     sCmd;
	spiSlavePkg::dLenT       sDLen;
	logic                    sREd;
	logic                    frameDone;
	spiSlavePkg::wordT       sMiso;
	// Arbiter to register file
	spiSlavePkg::wordT       usiWd;
	logic [`BUS_ADRS_BIT-1:0] usiAdrs;
	logic                    usiWEd;
	spiSlavePkg::wordT       usiRd;
	logic                    bulkEn;

	spiSlaveSignal uSignal (
		.iSysClk(iSysClk), .rstN(rstN),
		.sclk(sclk), .csN(csN), .mosi(mosi), .sMiso(sMiso),
		.miso(miso), .sRd(sRd), .sAdrs(sAdrs), .sCmd(sCmd),
		.sDLen(sDLen), .sREd(sREd), .frameDone(frameDone)
	);

	spiSignalMux #(
		.BUS_ADRS_BIT(`BUS_ADRS_BIT),
		.UFI_BUS_WIDTH(`UFI_BUS_WIDTH)
	) uMux (
		.iSysClk(iSysClk), .rstN(rstN),
		.sRd(sRd), .sAdrs(sAdrs), .sCmd(sCmd), .sDLen(sDLen), .sREd(sREd),
		.sMiso(sMiso), .usiRd(usiRd), .bulkEn(bulkEn),
		.usiWd(usiWd), .usiAdrs(usiAdrs), .usiWEd(usiWEd),
		.ufiWd(ufiWd), .ufiAdrs(ufiAdrs), .ufiEd(ufiEd), .ufiVd(ufiVd)
	);

	csrRegFile uCsr (
		.iSysClk(iSysClk), .rstN(rstN),
		.usiWd(usiWd), .usiAdrs(usiAdrs), .usiWEd(usiWEd),
		.frameDone(frameDone), .usiRd(usiRd), .bulkEn(bulkEn)
	);

endmodule

// ==== src/spiSlave_cfg.svh ====
/*
 SPI slave build constants
 Bus widths and the register map
*/
`ifndef SPI_SLAVE_CFG_SVH
`define SPI_SLAVE_CFG_SVH

// Register bus address width
`define BUS_ADRS_BIT 16
// Bulk write bus data width
`define UFI_BUS_WIDTH 16

// Number of scratch registers
`define CSR_SCRATCH_NUM 2

// Register map, full address decode
`define CSR_ID_ADRS       32'h0000_0000
`define CSR_CTRL_ADRS     32'h0000_0004
`define CSR_SCRATCH0_ADRS 32'h0000_0008
`define CSR_SCRATCH1_ADRS 32'h0000_000c
`define CSR_FRAMES_ADRS   32'h0000_0010

// Identity word, ASCII "SPI1"
`define CSR_ID_VALUE 32'h5350_4931

`endif

// ==== tests/spiSlaveTb.sv ====
/*
 SPI slave testbench
 Bit-bangs SPI frames into the top level, watches the bulk bus, checks registers
*/
`timescale 1ns/1ns
`include "spiSlave_cfg.svh"

module spiSlaveTb;

	// ------------------------------
	// Run constants
	// ------------------------------

	// Half sclk period in iSysClk cycles, sclk = iSysClk/8
	localparam int HALF_SCLK = 4;
	// Words in the bulk transfer test
	localparam int BULK_WORDS = 8;
	// Upper bound on frames in the whole run
	localparam int NUM_FRAMES = 20;
	// Command, address, length, then the longest payload
	localparam int MAX_FRAME_BITS = 8 + 32 + 16 + 32 * BULK_WORDS;
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * MAX_FRAME_BITS * 2 * HALF_SCLK + 2000;
	// Bulk writes land a few cycles after the last bit
	localparam int WRITE_WAIT_LIMIT = 64;

	// DUT pins
	logic                        iSysClk;
	logic                        rstN;
	logic                        sclk;
	logic                        csN;
	logic                        mosi;
	logic                        miso;
	logic [`UFI_BUS_WIDTH-1:0]   ufiWd;
	spiSlavePkg::adrsT           ufiAdrs;
	logic                        ufiEd;
	logic                        ufiVd;

	// Bookkeeping
	int          errCnt;
	int          checkCnt;
	int          framesSent;
	logic [31:0] lcgState;
	logic [31:0] scratchVal [2];
	// Payload of the next frame
	logic [31:0] txWords [$];
	// Bulk bus capture
	logic [31:0] dataQ [$];
	logic [31:0] adrsQ [$];
	logic        vdSeen;

	spiSlaveTop UUT (
		.iSysClk(iSysClk), .rstN(rstN),
		.sclk(sclk), .csN(csN), .mosi(mosi), .miso(miso),
		.ufiWd(ufiWd), .ufiAdrs(ufiAdrs), .ufiEd(ufiEd), .ufiVd(ufiVd)
	);

	// 4 ns clock
	always #2 iSysClk = ~iSysClk;

	// ------------------------------
	// Bulk bus monitor
	// ------------------------------

	// Mid-cycle sample, outputs settled
	always @(negedge iSysClk)
	begin
		if (ufiEd)
		begin
			dataQ.push_back(32'(ufiWd));
			adrsQ.push_back(ufiAdrs);
		end
		if (ufiVd)
			vdSeen = 1'b1;
	end

	// Hard stop if a test stalls
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge iSysClk);
		$display("Watchdog expired: the run did not finish within %0d clock cycles",
			WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", checkCnt, errCnt);
		$display("Test failures found");
		$finish;
	end

	// LCG, numerical recipes constants
	function logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCnt++;
		assert (actual === expected)
		else
		begin
			errCnt++;
			$display("error %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	// ------------------------------
	// SPI host driver
	// ------------------------------

	// One mode 0 bit, miso read just before the rising edge
	task automatic shiftBit(input logic outBit, output logic inBit);
		mosi = outBit;
		repeat (HALF_SCLK) @(negedge iSysClk);
		inBit = miso;
		sclk  = 1'b1;
		repeat (HALF_SCLK) @(negedge iSysClk);
		sclk = 1'b0;
	endtask

	// MSB first, low nBits of outVal
	task automatic shiftBits(input logic [31:0] outVal, input int nBits,
		output logic [31:0] inVal);
		logic [31:0] outSr;
		logic        inBit;
		outSr = outVal << (32 - nBits);
		inVal = '0;
		for (int i = 0; i < nBits; i++)
		begin
			shiftBit(outSr[31], inBit);
			outSr = outSr << 1;
			inVal = {inVal[30:0], inBit};
		end
	endtask

	task automatic selectSlave();
		@(negedge iSysClk);
		sclk = 1'b0;
		csN  = 1'b0;
		// Let the synchronizer see csN before the first edge
		repeat (HALF_SCLK) @(negedge iSysClk);
	endtask

	task automatic deselectSlave();
		repeat (HALF_SCLK) @(negedge iSysClk);
		csN  = 1'b1;
		mosi = 1'b0;
		repeat (2 * HALF_SCLK) @(negedge iSysClk);
	endtask

	// Full frame, data words from txWords, last received word returned
	task automatic spiFrame(input logic [1:0] cmd, input logic [31:0] adrs,
		input logic [15:0] len, output logic [31:0] rdWord);
		logic [31:0] discard;
		selectSlave();
		shiftBits({30'd0, cmd}, 8, discard);
		shiftBits(adrs, 32, discard);
		shiftBits({16'd0, len}, 16, discard);
		rdWord = '0;
		for (int i = 0; i < txWords.size(); i++)
			shiftBits(txWords[i], 32, rdWord);
		deselectSlave();
		framesSent++;
	endtask

	task automatic writeCsr(input logic [31:0] adrs, input logic [31:0] data);
		logic [31:0] discard;
		txWords.delete();
		txWords.push_back(data);
		spiFrame(spiSlavePkg::csrWrite, adrs, 16'd1, discard);
	endtask

	task automatic readCsr(input logic [31:0] adrs, output logic [31:0] data);
		txWords.delete();
		txWords.push_back(32'd0);
		spiFrame(spiSlavePkg::csrRead, adrs, 16'd1, data);
	endtask

	// Deselect halfway through the address
	task automatic abortFrame(input logic [1:0] cmd, input logic [31:0] adrs);
		logic [31:0] discard;
		selectSlave();
		shiftBits({30'd0, cmd}, 8, discard);
		shiftBits({16'd0, adrs[31:16]}, 16, discard);
		deselectSlave();
	endtask

	task automatic waitBulkWrites(input string testName, input int n);
		int waited;
		waited = 0;
		while ((dataQ.size() < n) && (waited < WRITE_WAIT_LIMIT))
		begin
			@(negedge iSysClk);
			waited++;
		end
		checkCnt++;
		assert (dataQ.size() >= n)
		else
		begin
			errCnt++;
			$display("%s: timed out waiting for %0d bulk writes, only %0d arrived",
				testName, n, dataQ.size());
		end
	endtask

	// ------------------------------
	// Directed tests
	// ------------------------------
	task automatic testIdentity();
		logic [31:0] rd;
		readCsr(`CSR_ID_ADRS, rd);
		checkValue("identity", `CSR_ID_VALUE, rd);
		// Bulk enable clear out of reset
		readCsr(`CSR_CTRL_ADRS, rd);
		checkValue("identity ctrl", 32'd0, rd);
	endtask

	task automatic testScratch();
		logic [31:0] rd;
		scratchVal[0] = nextRandom();
		scratchVal[1] = nextRandom();
		writeCsr(`CSR_SCRATCH0_ADRS, scratchVal[0]);
		writeCsr(`CSR_SCRATCH1_ADRS, scratchVal[1]);
		readCsr(`CSR_SCRATCH0_ADRS, rd);
		checkValue("scratch0", scratchVal[0], rd);
		readCsr(`CSR_SCRATCH1_ADRS, rd);
		checkValue("scratch1", scratchVal[1], rd);
	endtask

	task automatic testBulkDisabled();
		logic [31:0] discard;
		dataQ.delete();
		adrsQ.delete();
		vdSeen = 1'b0;
		txWords.delete();
		for (int i = 0; i < 4; i++)
			txWords.push_back(nextRandom());
		spiFrame(spiSlavePkg::bulkWrite, 32'h0000_0200, 16'd4, discard);
		checkValue("bulk disabled writes", 32'd0, 32'(dataQ.size()));
		checkCnt++;
		assert (vdSeen)
		else
		begin
			errCnt++;
			$display("bulk disabled: ufiVd never went high during the frame");
		end
		checkValue("bulk disabled valid after", 32'd0, {31'd0, ufiVd});
	endtask

	task automatic testBulkTransfer();
		logic [31:0] rd;
		logic [31:0] base;
		logic [31:0] mask;
		writeCsr(`CSR_CTRL_ADRS, 32'd1);
		readCsr(`CSR_CTRL_ADRS, rd);
		checkValue("bulk enable", 32'd1, rd);
		// Low bus-width bits of each word survive
		mask = (32'd1 << `UFI_BUS_WIDTH) - 32'd1;
		base = nextRandom() & 32'h00ff_fff0;
		dataQ.delete();
		adrsQ.delete();
		txWords.delete();
		for (int i = 0; i < BULK_WORDS; i++)
			txWords.push_back(nextRandom());
		spiFrame(spiSlavePkg::bulkWrite, base, 16'(BULK_WORDS), rd);
		waitBulkWrites("bulk transfer", BULK_WORDS);
		checkValue("bulk transfer count", 32'(BULK_WORDS), 32'(dataQ.size()));
		for (int i = 0; (i < BULK_WORDS) && (i < dataQ.size()); i++)
		begin
			checkValue("bulk transfer data", txWords[i] & mask, dataQ[i]);
			checkValue("bulk transfer address", base + 32'(i), adrsQ[i]);
		end
		checkValue("bulk transfer valid after", 32'd0, {31'd0, ufiVd});
	endtask

	task automatic testFrameCounter();
		logic [31:0] rd;
		int          expected;
		// Reading frame completes after the counter is sampled
		expected = framesSent;
		readCsr(`CSR_FRAMES_ADRS, rd);
		checkValue("frame counter", 32'(expected), rd);
	endtask

	task automatic testAbort();
		logic [31:0] rd;
		int          expected;
		expected = framesSent;
		abortFrame(spiSlavePkg::csrWrite, `CSR_SCRATCH0_ADRS);
		readCsr(`CSR_SCRATCH0_ADRS, rd);
		checkValue("abort scratch0", scratchVal[0], rd);
		readCsr(`CSR_SCRATCH1_ADRS, rd);
		checkValue("abort scratch1", scratchVal[1], rd);
		// Two reads above complete before this one samples
		readCsr(`CSR_FRAMES_ADRS, rd);
		checkValue("abort frame counter", 32'(expected + 2), rd);
		readCsr(`CSR_ID_ADRS, rd);
		checkValue("abort identity", `CSR_ID_VALUE, rd);
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		iSysClk    = 1'b0;
		rstN       = 1'b0;
		sclk       = 1'b0;
		csN        = 1'b1;
		mosi       = 1'b0;
		errCnt     = 0;
		checkCnt   = 0;
		framesSent = 0;
		vdSeen     = 1'b0;
		lcgState   = 32'h527e;
		repeat (4) @(negedge iSysClk);
		rstN = 1'b1;
		repeat (4) @(negedge iSysClk);

		testIdentity();
		testScratch();
		testBulkDisabled();
		testBulkTransfer();
		testFrameCounter();
		testAbort();

		$display("Checks: %0d, errors: %0d", checkCnt, errCnt);
		if (errCnt == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
